/* rtl/stack_exec_pkg.sv */
package stack_exec_pkg;

        localparam int word_width = 32;
        localparam int shamt_width = $clog2(word_width);

        // upper six bits of the instruction byte.
        typedef enum logic [5:0] {
                i_movez     = 6'h00,
                i_rareadz   = 6'h01,
                i_rereadiz  = 6'h02,
                i_writeprez = 6'h03,
                i_inc       = 6'h08,
                i_dec       = 6'h09,
                i_carry     = 6'h0a,
                i_borrow    = 6'h0b,
                i_inv       = 6'h0c,
                i_add       = 6'h10,
                i_sub       = 6'h11,
                i_lsl       = 6'h12,
                i_lsr       = 6'h13,
                i_csl       = 6'h14,
                i_csr       = 6'h15,
                i_asr       = 6'h16,
                i_and       = 6'h17,
                i_or        = 6'h18,
                i_xor       = 6'h19,
                i_addi      = 6'h20,
                i_addi8     = 6'h21,
                i_subi      = 6'h22,
                i_lsli      = 6'h23,
                i_csli      = 6'h24,
                i_andi      = 6'h25,
                i_ori       = 6'h26,
                i_xori      = 6'h27,
                i_bra       = 6'h30,
                i_beq       = 6'h31,
                i_loop      = 6'h32
        } instr_op_e;

        typedef enum logic [3:0] {
                op_nop = 4'd0,
                op_add = 4'd1,
                op_and = 4'd2,
                op_or  = 4'd3,
                op_xor = 4'd4,
                op_lsl = 4'd5,
                op_lsr = 4'd6,
                op_asr = 4'd7,
                op_csl = 4'd8,
                op_csr = 4'd9
        } alu_op_e;

        typedef struct packed {
                logic                       valid;
                logic [7:0]                 instr;
                logic [word_width-1:0]      imm;
                logic [word_width-1:0]      top;
                logic [word_width-1:0]      second;
                logic [word_width-1:0]      pc;
                logic [3:0][word_width-1:0] dcs;
                logic [3:0][word_width-1:0] dc_vals;
        } exec_in_t;

        typedef struct packed {
                logic [word_width-1:0] a;
                logic [word_width-1:0] b;
                logic                  ic;
                alu_op_e               op;
                logic                  store_carry;
                logic                  store_overflow;
        } alu_req_t;

        typedef struct packed {
                logic [word_width-1:0] result;
                logic                  carry_out;
                logic                  overflow;
        } alu_res_t;

        typedef struct packed {
                logic                  valid;
                logic [word_width-1:0] result;
                logic                  carry;
                logic                  overflow;
        } exec_out_t;

endpackage

/* rtl/alu_control.sv */
`timescale 1ns/1ns

module alu_control import stack_exec_pkg::*; (
        input  exec_in_t instr_in,
        input  logic     carry,
        output alu_req_t req
);

        logic [word_width-1:0] imm8;
        logic [word_width-1:0] imm16;
        logic [word_width-1:0] simm8;
        logic [word_width-1:0] simm16;
        logic [1:0]            dc_sel;
        instr_op_e             opcode;

        assign imm8   = {{(word_width-8){1'b0}}, instr_in.imm[7:0]};
        assign imm16  = {{(word_width-16){1'b0}}, instr_in.imm[15:0]};
        assign simm8  = {{(word_width-8){instr_in.imm[7]}}, instr_in.imm[7:0]};
        assign simm16 = {{(word_width-16){instr_in.imm[15]}}, instr_in.imm[15:0]};

        // low two bits pick the data counter.
        assign dc_sel = instr_in.instr[1:0];
        assign opcode = instr_op_e'(instr_in.instr[7:2]);

        always_comb begin
                req.a = '0;
                req.b = '0;
                req.ic = 1'b0;
                req.op = op_nop;
                req.store_carry = 1'b0;
                req.store_overflow = 1'b0;

                case (opcode)
                i_movez: begin
                        req.a = instr_in.dcs[dc_sel];
                        req.b = simm8;
                        req.ic = 1'b1;
                        req.op = op_add;
                end
                i_rareadz: begin
                        req.a = instr_in.dcs[dc_sel];
                        req.b = instr_in.top;
                        req.op = op_add;
                end
                i_rereadiz: begin
                        req.a = instr_in.dc_vals[dc_sel];
                        req.b = imm8;
                        req.op = op_add;
                end
                i_writeprez: begin
                        req.a = instr_in.dcs[dc_sel];
                        req.b = simm8;
                        req.op = op_add;
                end
                // inc/dec/carry/borrow differ only in a and carry-in.
                i_inc, i_dec, i_carry, i_borrow: begin
                        req.a = (opcode == i_dec || opcode == i_borrow) ? '1 : '0;
                        req.b = instr_in.top;
                        req.ic = (opcode == i_inc) ? 1'b1 :
                                 (opcode == i_dec) ? 1'b0 : carry;
                        req.op = op_add;
                        req.store_carry = 1'b1;
                        req.store_overflow = 1'b1;
                end
                i_inv: begin
                        req.a = '1;
                        req.b = instr_in.top;
                        req.op = op_xor;
                end
                i_add, i_addi, i_addi8: begin
                        req.a = (opcode == i_add)  ? instr_in.second :
                                (opcode == i_addi) ? instr_in.imm : simm8;
                        req.b = instr_in.top;
                        req.op = op_add;
                        req.store_carry = 1'b1;
                        req.store_overflow = 1'b1;
                end
                // subtract as a + ~top + 1.
                i_sub, i_subi: begin
                        req.a = (opcode == i_sub) ? instr_in.second : instr_in.imm;
                        req.b = ~instr_in.top;
                        req.ic = 1'b1;
                        req.op = op_add;
                        req.store_carry = 1'b1;
                        req.store_overflow = 1'b1;
                end
                i_lsl, i_lsr, i_csl, i_csr, i_asr, i_and, i_or, i_xor: begin
                        req.a = instr_in.second;
                        req.b = instr_in.top;
                        case (opcode)
                        i_lsl:   req.op = op_lsl;
                        i_lsr:   req.op = op_lsr;
                        i_csl:   req.op = op_csl;
                        i_csr:   req.op = op_csr;
                        i_asr:   req.op = op_asr;
                        i_and:   req.op = op_and;
                        i_or:    req.op = op_or;
                        default: req.op = op_xor;
                        endcase
                end
                // negative shift count turns into a right shift.
                i_lsli: begin
                        req.a = instr_in.top;
                        req.b = imm8[7] ? -simm8 : imm8;
                        req.op = imm8[7] ? op_lsr : op_lsl;
                end
                i_csli: begin
                        req.a = instr_in.top;
                        req.b = simm8;
                        req.op = op_csl;
                end
                i_andi, i_ori, i_xori: begin
                        req.a = instr_in.top;
                        req.b = instr_in.imm;
                        req.op = (opcode == i_andi) ? op_and :
                                 (opcode == i_ori)  ? op_or : op_xor;
                end
                i_bra, i_beq: begin
                        req.a = instr_in.pc;
                        req.b = simm16;
                        req.op = op_add;
                end
                i_loop: begin
                        req.a = instr_in.pc;
                        req.b = imm16;
                        req.op = op_add;
                end
                default: begin
                        req.op = op_nop;
                end
                endcase
        end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu import stack_exec_pkg::*; (
        input  alu_req_t req,
        output alu_res_t res
);

        logic [word_width:0]       sum;
        logic [shamt_width-1:0]    shamt;
        logic [2*word_width-1:0]   rot_l;
        logic [2*word_width-1:0]   rot_r;
        logic                      add_ovf;

        assign sum = {1'b0, req.a} + {1'b0, req.b} + {{word_width{1'b0}}, req.ic};

        // operands agree in sign but the sum does not.
        assign add_ovf = (req.a[word_width-1] == req.b[word_width-1]) &&
                         (sum[word_width-1] != req.a[word_width-1]);

        // shift amount wraps at the word width.
        assign shamt = req.b[shamt_width-1:0];

        assign rot_l = {req.a, req.a} << shamt;
        assign rot_r = {req.a, req.a} >> shamt;

        always_comb begin
                res.carry_out = 1'b0;
                res.overflow = 1'b0;

                case (req.op)
                op_add: begin
                        res.result = sum[word_width-1:0];
                        res.carry_out = sum[word_width];
                        res.overflow = add_ovf;
                end
                op_and: begin
                        res.result = req.a & req.b;
                end
                op_or: begin
                        res.result = req.a | req.b;
                end
                op_xor: begin
                        res.result = req.a ^ req.b;
                end
                op_lsl: begin
                        res.result = req.a << shamt;
                end
                op_lsr: begin
                        res.result = req.a >> shamt;
                end
                op_asr: begin
                        res.result = $signed(req.a) >>> shamt;
                end
                // rotate via a doubled word.
                op_csl: begin
                        res.result = rot_l[2*word_width-1:word_width];
                end
                op_csr: begin
                        res.result = rot_r[word_width-1:0];
                end
                default: begin
                        res.result = '0;
                end
                endcase
        end

endmodule

/* rtl/exec_writeback.sv */
`timescale 1ns/1ns

module exec_writeback import stack_exec_pkg::*; (
        input  logic      clk,
        input  logic      arst_n,
        input  logic      valid,
        input  logic      store_carry,
        input  logic      store_overflow,
        input  alu_res_t  res,
        output exec_out_t out
);

        logic                  valid_q;
        logic [word_width-1:0] result_q;
        logic                  carry_q;
        logic                  overflow_q;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        valid_q <= 1'b0;
                        result_q <= '0;
                        carry_q <= 1'b0;
                        overflow_q <= 1'b0;
                end else begin
                        valid_q <= valid;
                        if (valid) begin
                                result_q <= res.result;
                        end
                        // flags are kept separately.
                        if (valid && store_carry) begin
                                carry_q <= res.carry_out;
                        end
                        if (valid && store_overflow) begin
                                overflow_q <= res.overflow;
                        end
                end
        end

        assign out.valid = valid_q;
        assign out.result = result_q;
        assign out.carry = carry_q;
        assign out.overflow = overflow_q;

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import stack_exec_pkg::*; (
        input  logic      clk,
        input  logic      arst_n,
        input  exec_in_t  instr_in,
        output exec_out_t exec_out
);

        alu_req_t req;
        alu_res_t res;

        // stored carry goes back to the operand select.
        alu_control u_alu_control (
                .instr_in (instr_in),
                .carry    (exec_out.carry),
                .req      (req)
        );

        alu u_alu (
                .req (req),
                .res (res)
        );

        exec_writeback u_exec_writeback (
                .clk            (clk),
                .arst_n         (arst_n),
                .valid          (instr_in.valid),
                .store_carry    (req.store_carry),
                .store_overflow (req.store_overflow),
                .res            (res),
                .out            (exec_out)
        );

endmodule

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef logic [word_width-1:0] word_t;

typedef struct packed {
        word_t result;
        logic  carry;
        logic  overflow;
        logic  sets_flags;
} model_t;

// carry is bit 32 of the wide sum.
function automatic model_t add_rule(input word_t a, input word_t b, input logic cin);
        model_t m;
        longint s;
        m = '0;
        s = longint'(a) + longint'(b) + longint'(cin);
        m.result = s[word_width-1:0];
        m.carry = s[word_width];
        m.overflow = (a[word_width-1] == b[word_width-1]) &&
                     (m.result[word_width-1] != a[word_width-1]);
        return m;
endfunction

function automatic word_t shift_arith(input word_t a, input int n);
        word_t r;
        r = a;
        for (int i = 0; i < n; i++) begin
                r = {r[word_width-1], r[word_width-1:1]};
        end
        return r;
endfunction

function automatic word_t rotate_left(input word_t a, input int n);
        return (a << n) | (a >> (word_width - n));
endfunction

function automatic model_t model_exec(input exec_in_t x, input logic cin);
        model_t     m;
        word_t      s8;
        word_t      z8;
        word_t      s16;
        word_t      z16;
        int         n;
        int         n8;
        logic [1:0] k;
        s8 = word_t'($signed(x.imm[7:0]));
        z8 = word_t'(x.imm[7:0]);
        s16 = word_t'($signed(x.imm[15:0]));
        z16 = word_t'(x.imm[15:0]);
        n = int'(x.top % word_width);
        n8 = int'(x.imm[7:0]);
        k = x.instr[1:0];
        m = '0;
        case (instr_op_e'(x.instr[7:2]))
        i_movez:     m = add_rule(x.dcs[k], s8, 1'b1);
        i_rareadz:   m = add_rule(x.dcs[k], x.top, 1'b0);
        i_rereadiz:  m = add_rule(x.dc_vals[k], z8, 1'b0);
        i_writeprez: m = add_rule(x.dcs[k], s8, 1'b0);
        i_inc:       m = add_rule('0, x.top, 1'b1);
        i_dec:       m = add_rule('1, x.top, 1'b0);
        i_carry:     m = add_rule('0, x.top, cin);
        i_borrow:    m = add_rule('1, x.top, cin);
        i_inv:       m.result = ~x.top;
        i_add:       m = add_rule(x.second, x.top, 1'b0);
        i_sub:       m = add_rule(x.second, ~x.top, 1'b1);
        i_addi:      m = add_rule(x.imm, x.top, 1'b0);
        i_addi8:     m = add_rule(s8, x.top, 1'b0);
        i_subi:      m = add_rule(x.imm, ~x.top, 1'b1);
        i_lsl:       m.result = x.second << n;
        i_lsr:       m.result = x.second >> n;
        i_asr:       m.result = shift_arith(x.second, n);
        i_csl:       m.result = rotate_left(x.second, n);
        i_csr:       m.result = rotate_left(x.second, word_width - n);
        i_and:       m.result = x.second & x.top;
        i_or:        m.result = x.second | x.top;
        i_xor:       m.result = x.second ^ x.top;
        // negative count shifts right by its magnitude.
        i_lsli:      m.result = x.imm[7] ? x.top >> ((256 - n8) % word_width) :
                                           x.top << (n8 % word_width);
        i_csli:      m.result = rotate_left(x.top, n8 % word_width);
        i_andi:      m.result = x.top & x.imm;
        i_ori:       m.result = x.top | x.imm;
        i_xori:      m.result = x.top ^ x.imm;
        i_bra:       m.result = x.pc + s16;
        i_beq:       m.result = x.pc + s16;
        i_loop:      m.result = x.pc + z16;
        default:     m.result = '0;
        endcase
        m.sets_flags = (x.instr[7:2] inside {i_add, i_sub, i_addi, i_addi8, i_subi,
                                             i_inc, i_dec, i_carry, i_borrow});
        return m;
endfunction

`endif

/* test/tb_execute_stage.sv */
`timescale 1ns/1ns

module tb_execute_stage import stack_exec_pkg::*;;

        `include "tb_ref_model.svh"

        localparam int max_cycles = 2000;

        logic      clk;
        logic      arst_n;
        exec_in_t  din;
        exec_out_t dout;
        int        cycles;
        int        errors;
        int        checks;

        // what the output must show after the next edge.
        logic      exp_valid;
        word_t     exp_result;
        logic      exp_carry;
        logic      exp_overflow;

        execute_stage i_dut (
                .clk      (clk),
                .arst_n   (arst_n),
                .instr_in (din),
                .exec_out (dout)
        );

        initial clk = 1'b0;
        always #5 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= max_cycles) begin
                        $display("timeout: run did not end within %0d cycles", max_cycles);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        function automatic exec_in_t make_instr(input instr_op_e op, input logic [1:0] sel,
                                                input word_t imm, input word_t top,
                                                input word_t second);
                exec_in_t x;
                x.valid = 1'b1;
                x.instr = {op, sel};
                x.imm = imm;
                x.top = top;
                x.second = second;
                x.pc = $urandom;
                for (int k = 0; k < 4; k++) begin
                        x.dcs[k] = $urandom;
                        x.dc_vals[k] = $urandom;
                end
                return x;
        endfunction

        task automatic compare_out();
                checks++;
                assert (dout.valid == exp_valid) else begin
                        errors++;
                        $display("ERR out.valid expected %h got %h", exp_valid, dout.valid);
                end
                assert (dout.result == exp_result) else begin
                        errors++;
                        $display("ERR out.result expected %h got %h", exp_result, dout.result);
                end
                assert (dout.carry == exp_carry) else begin
                        errors++;
                        $display("ERR out.carry expected %h got %h", exp_carry, dout.carry);
                end
                assert (dout.overflow == exp_overflow) else begin
                        errors++;
                        $display("ERR out.overflow expected %h got %h",
                                 exp_overflow, dout.overflow);
                end
        endtask

        // drives one instruction and checks the one before it.
        task automatic step(input exec_in_t x);
                model_t m;
                @(posedge clk);
                din <= x;
                @(negedge clk);
                compare_out();
                exp_valid = x.valid;
                if (x.valid) begin
                        m = model_exec(x, exp_carry);
                        exp_result = m.result;
                        if (m.sets_flags) begin
                                exp_carry = m.carry;
                                exp_overflow = m.overflow;
                        end
                end
        endtask

        task automatic expect_value(input word_t r, input logic c);
                checks++;
                assert (dout.result == r && dout.carry == c) else begin
                        errors++;
                        $display("ERR out.result expected %h got %h, out.carry expected %h got %h",
                                 r, dout.result, c, dout.carry);
                end
        endtask

        task automatic arith_ops();
                word_t a;
                word_t b;
                for (int i = 0; i < 10; i++) begin
                        a = (i == 0) ? 32'h7fff_ffff : $urandom;
                        b = (i == 0) ? a : $urandom;
                        step(make_instr(i_add, 2'd0, $urandom, a, b));
                        step(make_instr(i_sub, 2'd0, $urandom, a, b));
                        step(make_instr(i_addi, 2'd0, $urandom, a, b));
                        step(make_instr(i_addi8, 2'd0, $urandom, a, b));
                        step(make_instr(i_subi, 2'd0, $urandom, a, b));
                end
        endtask

        task automatic inc_dec_carry();
                step(make_instr(i_inc, 2'd1, 0, '1, 0));
                step(make_instr(i_dec, 2'd2, 0, '0, 0));
                expect_value('0, 1'b1);
                step(make_instr(i_add, 2'd0, 0, 32'h1, 32'hffff_ffff));
                expect_value('1, 1'b0);
                // carry from the add is used right away.
                step(make_instr(i_carry, 2'd0, 0, 32'h1234_5678, 0));
                step(make_instr(i_borrow, 2'd0, 0, 32'h1234_5678, 0));
                expect_value(32'h1234_5679, 1'b0);
                step(make_instr(i_add, 2'd0, 0, 32'h8000_0000, 32'h8000_0001));
                step(make_instr(i_borrow, 2'd3, 0, $urandom, 0));
        endtask

        task automatic logic_and_shifts();
                instr_op_e ops[14] = '{i_and, i_or, i_xor, i_inv, i_lsl, i_lsr, i_asr,
                                       i_csl, i_csr, i_andi, i_ori, i_xori, i_csli, i_lsli};
                word_t     imm;
                // both flags set first so a stray update shows.
                step(make_instr(i_add, 2'd0, 0, 32'h8000_0000, 32'h8000_0000));
                for (int i = 0; i < 4; i++) begin
                        foreach (ops[j]) begin
                                imm = $urandom;
                                imm[7] = i[0];
                                step(make_instr(ops[j], 2'($urandom), imm, $urandom, $urandom));
                        end
                end
        endtask

        task automatic counter_forms();
                for (int k = 0; k < 4; k++) begin
                        step(make_instr(i_movez, 2'(k), $urandom, $urandom, $urandom));
                        step(make_instr(i_rareadz, 2'(k), $urandom, $urandom, $urandom));
                        step(make_instr(i_rereadiz, 2'(k), $urandom, $urandom, $urandom));
                        step(make_instr(i_writeprez, 2'(k), $urandom, $urandom, $urandom));
                end
        endtask

        task automatic branch_targets();
                word_t imm;
                for (int i = 0; i < 2; i++) begin
                        imm = $urandom;
                        imm[15] = i[0];
                        step(make_instr(i_bra, 2'd0, imm, $urandom, $urandom));
                        step(make_instr(i_beq, 2'd1, imm, $urandom, $urandom));
                        step(make_instr(i_loop, 2'd2, imm, $urandom, $urandom));
                end
        endtask

        task automatic random_stream();
                instr_op_e op;
                instr_op_e ops[$];
                exec_in_t  x;
                op = op.first();
                do begin
                        ops.push_back(op);
                        op = op.next();
                end while (op != op.first());
                // about one cycle in four has valid low.
                for (int i = 0; i < 200; i++) begin
                        x = make_instr(ops[$urandom % ops.size()], 2'($urandom),
                                       $urandom, $urandom, $urandom);
                        x.valid = ($urandom % 4) != 0;
                        step(x);
                end
        endtask

        initial begin
                exec_in_t idle;
                void'($urandom(53266));
                din <= '0;
                arst_n <= 1'b0;
                exp_valid = 1'b0;
                exp_result = '0;
                exp_carry = 1'b0;
                exp_overflow = 1'b0;
                repeat (10) @(posedge clk);
                arst_n <= 1'b1;
                arith_ops();
                inc_dec_carry();
                logic_and_shifts();
                counter_forms();
                branch_targets();
                random_stream();
                idle = make_instr(i_add, 2'd0, $urandom, $urandom, $urandom);
                idle.valid = 1'b0;
                step(idle);
                $display("errors: %0d in %0d output compares", errors, checks);
                if (errors == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

/* all.f */
+incdir+test
rtl/stack_exec_pkg.sv
rtl/alu_control.sv
rtl/alu.sv
rtl/exec_writeback.sv
rtl/execute_stage.sv
test/tb_execute_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_execute_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
